// File: design/rxdp_fifo_pkg.sv
// Receive datapath FIFO constants
// Word, bank and pointer widths shared by the FIFO blocks
package rxdp_fifo_pkg;

   // *************************************************************************
   // Widths and depths
   // *************************************************************************
   localparam int DWIDTH     = 40;   // Full word from the lanes
   localparam int BWIDTH     = 20;   // One bank holds half a word
   localparam int AWIDTH     = 4;    // Entry index
   localparam int DEPTH      = 16;   // Full-depth mode
   localparam int PS_DEPTH   = 8;    // Power saving, lower banks only
   localparam int BANK_DEPTH = 8;

   // *************************************************************************
   // Vector types
   // *************************************************************************
   typedef logic [DWIDTH-1:0]     fifo_word_t;
   typedef logic [BWIDTH-1:0]     bank_word_t;
   typedef logic [AWIDTH-1:0]     fifo_addr_t;
   typedef logic [AWIDTH:0]       fifo_ptr_t;    // MSB is the wrap bit
   typedef logic [AWIDTH:0]       fifo_cnt_t;    // 0 up to DEPTH
   typedef logic [BANK_DEPTH-1:0] bank_sel_t;    // One-hot row select

endpackage

// File: design/rxdp_cfg_pkg.sv
// Register block definitions of the receive FIFO
// APB types, register map and the control and status bundles
package rxdp_cfg_pkg;
   import rxdp_fifo_pkg::*;

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Byte addresses
   localparam apb_addr_t ADDR_CTRL   = 8'h00;
   localparam apb_addr_t ADDR_THRESH = 8'h04;
   localparam apb_addr_t ADDR_STATUS = 8'h08;

   localparam apb_data_t CTRL_RST   = 32'h0000_0003;  // Both stops, power saving, single read
   localparam apb_data_t THRESH_RST = 32'h0C10_0200;  // pfull 12, full 16, pempty 2, empty 0

   typedef enum logic [1:0] {
      PM_SAVE     = 2'b00,   // 8 entries
      PM_SAVE_ALT = 2'b01,   // 8 entries
      PM_FULL     = 2'b10    // 11 also gives 16 entries
   } power_mode_t;

   typedef enum logic {IDLE, ACCESS} apb_state_t;

   typedef struct packed {
      logic        stop_read;     // Refuse pops short of data
      logic        stop_write;    // Refuse pushes at depth
      logic        double_read;   // Two words per pop
      power_mode_t power_mode;
      fifo_cnt_t   th_empty;
      fifo_cnt_t   th_pempty;
      fifo_cnt_t   th_full;
      fifo_cnt_t   th_pfull;
   } fifo_cfg_t;

   typedef struct packed {
      logic overflow;    // Toggles in wr_clk per refused push
      logic underflow;   // rd_clk pulse per refused pop
      logic wr_empty;
      logic wr_pempty;
      logic wr_full;
      logic wr_pfull;
      logic rd_empty;
      logic rd_pempty;
      logic rd_full;
      logic rd_pfull;
   } fifo_stat_t;

endpackage

// File: design/rxdp_cfg_regs.sv
// APB register block of the receive FIFO
// Holds the FIFO controls and flag thresholds, and keeps overflow and
// underflow as sticky status bits cleared by writing 1
module rxdp_cfg_regs
   import rxdp_cfg_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rd_rst_n,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   input  fifo_stat_t stat,
   output apb_data_t  prdata,
   output logic       pready,
   output logic       pslverr,
   output fifo_cfg_t  cfg
);

   apb_state_t state;
   logic       acc;          // Access phase of a transfer
   logic       wr_acc;
   logic       addr_err;
   logic       sts_clr;      // Write to STATUS
   logic [2:0] ovf_sync;     // Two sync flops and edge history
   logic       ovf_evt;
   logic       ovf_sticky;
   logic       udf_sticky;

   function automatic fifo_cfg_t set_ctrl(fifo_cfg_t c, apb_data_t d);
      c.stop_read   = d[0];
      c.stop_write  = d[1];
      c.double_read = d[2];
      c.power_mode  = power_mode_t'(d[4:3]);
      return c;
   endfunction

   function automatic fifo_cfg_t set_thresh(fifo_cfg_t c, apb_data_t d);
      c.th_empty  = d[4:0];
      c.th_pempty = d[12:8];
      c.th_full   = d[20:16];
      c.th_pfull  = d[28:24];
      return c;
   endfunction

   // *************************************************************************
   // APB transfer FSM, setup then access, no wait states
   // *************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:    if (psel && !penable) state <= ACCESS;
            ACCESS:  state <= IDLE;   // Back to setup or idle
            default: state <= IDLE;
         endcase
      end
   end

   assign acc      = (state == ACCESS) && psel && penable;
   assign wr_acc   = acc && pwrite;
   assign sts_clr  = wr_acc && (paddr == ADDR_STATUS);
   assign addr_err = !(paddr inside {ADDR_CTRL, ADDR_THRESH, ADDR_STATUS}) ||
                     (pwrite && paddr == ADDR_STATUS);   // STATUS is W1C only
   assign pready   = acc;
   assign pslverr  = acc && addr_err;

   always_comb begin
      prdata = '0;
      if (acc && !pwrite) begin
         case (paddr)
            ADDR_CTRL:   prdata = {27'd0, cfg.power_mode, cfg.double_read,
                                   cfg.stop_write, cfg.stop_read};
            ADDR_THRESH: prdata = {3'd0, cfg.th_pfull, 3'd0, cfg.th_full,
                                   3'd0, cfg.th_pempty, 3'd0, cfg.th_empty};
            ADDR_STATUS: prdata = {30'd0, udf_sticky, ovf_sticky};
            default:     prdata = '0;
         endcase
      end
   end

   // Control registers, take effect on the access edge
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         cfg <= set_thresh(set_ctrl('0, CTRL_RST), THRESH_RST);
      end else if (wr_acc) begin
         if (paddr == ADDR_CTRL) cfg <= set_ctrl(cfg, pwdata);
         if (paddr == ADDR_THRESH) cfg <= set_thresh(cfg, pwdata);
      end
   end

   // *************************************************************************
   // Sticky status, overflow arrives as a wr_clk toggle
   // *************************************************************************
   assign ovf_evt = ovf_sync[2] ^ ovf_sync[1];   // One pulse per toggle

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         ovf_sync   <= '0;
         ovf_sticky <= 1'b0;
         udf_sticky <= 1'b0;
      end else begin
         ovf_sync   <= {ovf_sync[1:0], stat.overflow};
         // New event wins over a clear in the same cycle
         ovf_sticky <= ovf_evt || (ovf_sticky && !(sts_clr && pwdata[0]));
         udf_sticky <= stat.underflow || (udf_sticky && !(sts_clr && pwdata[1]));
      end
   end

   // Enable only inside a selected transfer
   a_penable_psel: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      penable |-> psel);

endmodule

// File: design/rxdp_fifo_ram.sv
// Storage bank of the receive FIFO
// Eight-row register file, one-hot write, two AND-OR read ports
module rxdp_fifo_ram
   import rxdp_fifo_pkg::*;
#(
   parameter int WIDTH = BWIDTH
) (
   input  logic             wr_clk,
   input  logic             wr_rst_n,
   input  logic             wr_en,
   input  bank_sel_t        wr_sel,     // One-hot row
   input  logic [WIDTH-1:0] wr_data,
   input  bank_sel_t        rd_sel,     // Head row
   input  bank_sel_t        rd_sel2,    // Row after the head
   output logic [WIDTH-1:0] rd_data,
   output logic [WIDTH-1:0] rd_data2
);

   logic [WIDTH-1:0] mem [BANK_DEPTH];

   always_ff @(posedge wr_clk) begin
      for (int i = 0; i < BANK_DEPTH; i++) begin
         if (wr_en && wr_sel[i]) begin
            mem[i] <= wr_data;
         end
      end
   end

   // Selected rows ORed together, no address decode here
   always_comb begin
      rd_data  = '0;
      rd_data2 = '0;
      for (int i = 0; i < BANK_DEPTH; i++) begin
         rd_data  |= {WIDTH{rd_sel[i]}} & mem[i];
         rd_data2 |= {WIDTH{rd_sel2[i]}} & mem[i];
      end
   end

   // Decoder upstream must never hit two rows
   a_wr_sel_onehot: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      wr_en |-> $onehot0(wr_sel));

endmodule

// File: design/rxdp_fifo_ptr.sv
// Pointer logic of the receive FIFO
// Binary pointers per domain, Gray copies crossing through two-flop
// synchronizers, and the occupancy seen in each domain
module rxdp_fifo_ptr
   import rxdp_fifo_pkg::*;
(
   input  logic      wr_clk,
   input  logic      wr_rst_n,
   input  logic      rd_clk,
   input  logic      rd_rst_n,
   input  logic      push,         // Accepted write
   input  logic      pop,          // Accepted read
   input  logic      pop_two,      // Double-read mode, quasi-static
   input  logic      full_depth,   // 16 entries, else 8
   output fifo_ptr_t wr_ptr_bin,
   output fifo_ptr_t rd_ptr_bin,
   output fifo_cnt_t wr_numdata,
   output fifo_cnt_t rd_numdata
);

   fifo_ptr_t wr_ptr_nxt;
   fifo_ptr_t wr_gray;        // Launched to rd_clk
   fifo_ptr_t wr_gray_s1;
   fifo_ptr_t wr_gray_s2;
   fifo_ptr_t wr_ptr_rsync;   // Write pointer as seen in rd_clk
   fifo_ptr_t rd_ptr_nxt;
   fifo_ptr_t rd_gray;        // Launched to wr_clk
   fifo_ptr_t rd_gray_s1;
   fifo_ptr_t rd_gray_s2;
   fifo_ptr_t rd_ptr_wsync;   // Read pointer as seen in wr_clk

   function automatic fifo_ptr_t bin2gray(fifo_ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic fifo_ptr_t gray2bin(fifo_ptr_t g);
      fifo_ptr_t b;
      b[AWIDTH] = g[AWIDTH];
      for (int i = AWIDTH - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Double read steps by two, so bit 0 holds still and the upper bits
   // get their own Gray code, keeping one bit change per pop
   function automatic fifo_ptr_t rd_encode(fifo_ptr_t b, logic two);
      fifo_ptr_t g;
      g = bin2gray(b >> 1);
      return two ? {g[AWIDTH-1:0], b[0]} : bin2gray(b);
   endfunction

   function automatic fifo_ptr_t rd_decode(fifo_ptr_t g, logic two);
      fifo_ptr_t b;
      b = gray2bin(g >> 1);
      return two ? {b[AWIDTH-1:0], g[0]} : gray2bin(g);
   endfunction

   always_comb begin
      wr_ptr_nxt = wr_ptr_bin + fifo_ptr_t'(push);
      rd_ptr_nxt = rd_ptr_bin;
      if (pop) rd_ptr_nxt = rd_ptr_bin + (pop_two ? fifo_ptr_t'(2) : fifo_ptr_t'(1));
      if (!full_depth) begin
         // Power saving wraps at 8, bit 3 turns into the wrap bit
         wr_ptr_nxt[AWIDTH] = 1'b0;
         rd_ptr_nxt[AWIDTH] = 1'b0;
      end
   end

   // *************************************************************************
   // Write domain, own pointer and read pointer sync
   // *************************************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_ptr_bin <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         wr_ptr_bin <= wr_ptr_nxt;
         wr_gray    <= bin2gray(wr_ptr_nxt);   // Registered before crossing
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // *************************************************************************
   // Read domain, own pointer and write pointer sync
   // *************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_ptr_bin <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         rd_ptr_bin <= rd_ptr_nxt;
         rd_gray    <= rd_encode(rd_ptr_nxt, pop_two);
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign rd_ptr_wsync = rd_decode(rd_gray_s2, pop_two);
   assign wr_ptr_rsync = gray2bin(wr_gray_s2);

   // Occupancy, local pointer minus the synchronized remote one
   always_comb begin
      wr_numdata = wr_ptr_bin - rd_ptr_wsync;
      rd_numdata = wr_ptr_rsync - rd_ptr_bin;
      if (!full_depth) begin
         wr_numdata[AWIDTH] = 1'b0;   // Modulo 16 in power saving
         rd_numdata[AWIDTH] = 1'b0;
      end
   end

   a_wr_depth: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      wr_numdata <= (full_depth ? fifo_cnt_t'(DEPTH) : fifo_cnt_t'(PS_DEPTH)));

endmodule

// File: design/rxdp_async_fifo.sv
// Receive datapath asynchronous FIFO
// Maps 40-bit words onto four 20-bit banks, selects the head and next
// words and registers the threshold flags in both clock domains
module rxdp_async_fifo
   import rxdp_fifo_pkg::*;
   import rxdp_cfg_pkg::*;
(
   input  logic       wr_clk,
   input  logic       wr_rst_n,
   input  logic       rd_clk,
   input  logic       rd_rst_n,
   input  logic       wr_en,
   input  fifo_word_t wr_data,
   input  logic       rd_en,
   input  fifo_cfg_t  cfg,            // Quasi-static, used in both domains
   output fifo_word_t rd_data,        // Head entry, fall-through
   output fifo_word_t rd_data_next,   // Entry after the head
   output fifo_stat_t stat
);

   logic       full_depth;
   fifo_cnt_t  depth_act;
   fifo_cnt_t  rd_need;       // Words one pop takes
   logic       push;
   logic       pop;
   logic       ovf_tgl;
   fifo_ptr_t  wr_ptr_bin;
   fifo_ptr_t  rd_ptr_bin;
   fifo_cnt_t  wr_numdata;
   fifo_cnt_t  rd_numdata;
   fifo_addr_t wr_addr;
   fifo_addr_t rd_addr;
   fifo_addr_t rd_inc;
   fifo_addr_t rd_addr2;
   bank_sel_t  wr_sel;
   bank_sel_t  rd_sel;
   bank_sel_t  rd_sel2;
   bank_word_t [DWIDTH/BWIDTH-1:0] bank_rd  [DEPTH/BANK_DEPTH];   // [pair] {high, low}
   bank_word_t [DWIDTH/BWIDTH-1:0] bank_rd2 [DEPTH/BANK_DEPTH];
   logic       wr_empty;
   logic       wr_pempty;
   logic       wr_full;
   logic       wr_pfull;
   logic       rd_empty;
   logic       rd_pempty;
   logic       rd_full;
   logic       rd_pfull;

   assign full_depth = cfg.power_mode[1];
   assign depth_act  = full_depth ? fifo_cnt_t'(DEPTH) : fifo_cnt_t'(PS_DEPTH);
   assign rd_need    = cfg.double_read ? fifo_cnt_t'(2) : fifo_cnt_t'(1);

   // Stops refuse a push at depth and a pop short of data
   assign push = wr_en && (!cfg.stop_write || wr_numdata < depth_act);
   assign pop  = rd_en && (!cfg.stop_read || rd_numdata >= rd_need);

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         ovf_tgl <= 1'b0;
      end else if (wr_en && !push) begin
         ovf_tgl <= !ovf_tgl;   // Crosses to the register block
      end
   end

   rxdp_fifo_ptr u_ptr (
      .wr_clk     (wr_clk),
      .wr_rst_n   (wr_rst_n),
      .rd_clk     (rd_clk),
      .rd_rst_n   (rd_rst_n),
      .push       (push),
      .pop        (pop),
      .pop_two    (cfg.double_read),
      .full_depth (full_depth),
      .wr_ptr_bin (wr_ptr_bin),
      .rd_ptr_bin (rd_ptr_bin),
      .wr_numdata (wr_numdata),
      .rd_numdata (rd_numdata)
   );

   // *************************************************************************
   // Bank mapping, bit 3 picks the pair; in power saving it is the wrap bit
   // *************************************************************************
   assign wr_addr  = {full_depth & wr_ptr_bin[AWIDTH-1], wr_ptr_bin[AWIDTH-2:0]};
   assign rd_addr  = {full_depth & rd_ptr_bin[AWIDTH-1], rd_ptr_bin[AWIDTH-2:0]};
   assign rd_inc   = rd_ptr_bin[AWIDTH-1:0] + 1'b1;
   assign rd_addr2 = {full_depth & rd_inc[AWIDTH-1], rd_inc[AWIDTH-2:0]};
   assign wr_sel   = bank_sel_t'(1) << wr_addr[AWIDTH-2:0];
   assign rd_sel   = bank_sel_t'(1) << rd_addr[AWIDTH-2:0];
   assign rd_sel2  = bank_sel_t'(1) << rd_addr2[AWIDTH-2:0];

   // Pair 0 lower entries, pair 1 upper; half 0 low bits, half 1 high bits
   for (genvar p = 0; p < DEPTH / BANK_DEPTH; p++) begin : g_pair
      for (genvar h = 0; h < DWIDTH / BWIDTH; h++) begin : g_half
         rxdp_fifo_ram #(.WIDTH(BWIDTH)) u_bank (
            .wr_clk   (wr_clk),
            .wr_rst_n (wr_rst_n),
            .wr_en    (push && (wr_addr[AWIDTH-1] == 1'(p))),
            .wr_sel   (wr_sel),
            .wr_data  (wr_data[h*BWIDTH +: BWIDTH]),
            .rd_sel   (rd_sel),
            .rd_sel2  (rd_sel2),
            .rd_data  (bank_rd[p][h]),
            .rd_data2 (bank_rd2[p][h])
         );
      end
   end

   assign rd_data      = bank_rd[rd_addr[AWIDTH-1]];
   assign rd_data_next = bank_rd2[rd_addr2[AWIDTH-1]];   // May sit in the other pair

   // *************************************************************************
   // Threshold flags, one register stage per domain
   // *************************************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_empty  <= 1'b1;
         wr_pempty <= 1'b1;
         wr_full   <= 1'b0;
         wr_pfull  <= 1'b0;
      end else begin
         wr_empty  <= (wr_numdata <= cfg.th_empty);
         wr_pempty <= (wr_numdata <= cfg.th_pempty);
         wr_full   <= (wr_numdata >= cfg.th_full);
         wr_pfull  <= (wr_numdata >= cfg.th_pfull);
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_empty  <= 1'b1;
         rd_pempty <= 1'b1;
         rd_full   <= 1'b0;
         rd_pfull  <= 1'b0;
      end else begin
         rd_empty  <= (rd_numdata <= cfg.th_empty);
         rd_pempty <= (rd_numdata <= cfg.th_pempty);
         rd_full   <= (rd_numdata >= cfg.th_full);
         rd_pfull  <= (rd_numdata >= cfg.th_pfull);
      end
   end

   assign stat = '{overflow: ovf_tgl, underflow: rd_en && !pop,
                   wr_empty: wr_empty, wr_pempty: wr_pempty,
                   wr_full: wr_full, wr_pfull: wr_pfull,
                   rd_empty: rd_empty, rd_pempty: rd_pempty,
                   rd_full: rd_full, rd_pfull: rd_pfull};

   // Dropped writes only follow wr_full or the push that filled the FIFO
   a_drop_after_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      (cfg.stop_write && cfg.th_full <= depth_act && wr_en && !push)
      |-> (wr_full || $past(push)));

endmodule

// File: design/rxdp_top.sv
// Receive datapath FIFO top level
// APB register block driving the asynchronous FIFO
module rxdp_top
   import rxdp_fifo_pkg::*;
   import rxdp_cfg_pkg::*;
(
   // APB slave, rd_clk domain
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   output apb_data_t  prdata,
   output logic       pready,
   output logic       pslverr,
   // Write port
   input  logic       wr_clk,
   input  logic       wr_rst_n,
   input  logic       wr_en,
   input  fifo_word_t wr_data,
   // Read port
   input  logic       rd_clk,
   input  logic       rd_rst_n,
   input  logic       rd_en,
   output fifo_word_t rd_data,
   output fifo_word_t rd_data_next,
   // Flags
   output logic       wr_full,
   output logic       wr_pfull,
   output logic       wr_empty,
   output logic       wr_pempty,
   output logic       rd_empty,
   output logic       rd_pempty,
   output logic       rd_full,
   output logic       rd_pfull
);

   fifo_cfg_t  cfg;
   fifo_stat_t stat;

   rxdp_cfg_regs u_regs (
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .stat     (stat),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .cfg      (cfg)
   );

   rxdp_async_fifo u_fifo (
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .rd_clk       (rd_clk),
      .rd_rst_n     (rd_rst_n),
      .wr_en        (wr_en),
      .wr_data      (wr_data),
      .rd_en        (rd_en),
      .cfg          (cfg),
      .rd_data      (rd_data),
      .rd_data_next (rd_data_next),
      .stat         (stat)
   );

   assign wr_full   = stat.wr_full;
   assign wr_pfull  = stat.wr_pfull;
   assign wr_empty  = stat.wr_empty;
   assign wr_pempty = stat.wr_pempty;
   assign rd_empty  = stat.rd_empty;
   assign rd_pempty = stat.rd_pempty;
   assign rd_full   = stat.rd_full;
   assign rd_pfull  = stat.rd_pfull;

endmodule

// File: verification/rxdp_tb.sv
// Testbench of the receive datapath FIFO
// Directed tests over APB and both FIFO ports, checked against a queue model
module rxdp_tb
   import rxdp_fifo_pkg::*;
   import rxdp_cfg_pkg::*;
();

   localparam int WR_PER   = 4;
   localparam int RD_PER   = 6;
   localparam int WAIT_MAX = 50;   // Cycles before a wait gives up

   // Rough test lengths in time units
   localparam int APB_T    = 4 * RD_PER;
   localparam int PUSH_T   = 2 * WR_PER;
   localparam int POP_T    = 2 * RD_PER;
   localparam int SETTLE_T = 6 * RD_PER;
   localparam int CROSS_T  = 5 * RD_PER;   // Write to read latency
   localparam int RESET_T  = 6 * RD_PER;
   localparam int REGS_T   = 11 * APB_T;
   localparam int ORDER_T  = 2 * APB_T + SETTLE_T + 16 * PUSH_T + CROSS_T + 16 * POP_T;
   localparam int PSAVE_T  = 8 * APB_T + 2 * SETTLE_T + 9 * PUSH_T + CROSS_T + 8 * POP_T;
   localparam int DOUBLE_T = 4 * APB_T + 3 * SETTLE_T + 8 * PUSH_T + CROSS_T + 4 * POP_T;
   localparam int THRESH_T = 2 * APB_T + 8 * SETTLE_T + 10 * PUSH_T + 10 * POP_T;
   localparam int UNDER_T  = 3 * APB_T + 3 * RD_PER;
   localparam int WATCHDOG_T = 2 * (RESET_T + REGS_T + ORDER_T + PSAVE_T + DOUBLE_T +
                                    THRESH_T + UNDER_T);

   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       wr_clk;
   logic       wr_rst_n;
   logic       wr_en;
   fifo_word_t wr_data;
   logic       rd_clk;
   logic       rd_rst_n;
   logic       rd_en;
   fifo_word_t rd_data;
   fifo_word_t rd_data_next;
   logic       wr_full;
   logic       wr_pfull;
   logic       wr_empty;
   logic       wr_pempty;
   logic       rd_empty;
   logic       rd_pempty;
   logic       rd_full;
   logic       rd_pfull;

   integer     seed   = 72887;
   int         errors = 0;
   int         checks = 0;
   fifo_word_t model_q [$];   // Words pushed and not yet popped

   rxdp_top dut0 (
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .wr_clk       (wr_clk),
      .wr_rst_n     (wr_rst_n),
      .wr_en        (wr_en),
      .wr_data      (wr_data),
      .rd_clk       (rd_clk),
      .rd_rst_n     (rd_rst_n),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .rd_data_next (rd_data_next),
      .wr_full      (wr_full),
      .wr_pfull     (wr_pfull),
      .wr_empty     (wr_empty),
      .wr_pempty    (wr_pempty),
      .rd_empty     (rd_empty),
      .rd_pempty    (rd_pempty),
      .rd_full      (rd_full),
      .rd_pfull     (rd_pfull)
   );

   initial begin
      wr_clk = 1'b0;
      forever #(WR_PER / 2) wr_clk = ~wr_clk;
   end

   initial begin
      rd_clk = 1'b0;
      forever #(RD_PER / 2) rd_clk = ~rd_clk;
   end

   // *************************************************************************
   // Helpers
   // *************************************************************************
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error: %s expected %0h actual %0h at %0t", name, expected, actual, $time);
      end
   endtask

   // CTRL and THRESH layouts from the register map
   function automatic apb_data_t ctrl_word(logic sr, logic sw, logic dbl, logic [1:0] pm);
      return {27'd0, pm, dbl, sw, sr};
   endfunction

   function automatic apb_data_t thresh_word(int e, int pe, int f, int pf);
      return {3'd0, 5'(pf), 3'd0, 5'(f), 3'd0, 5'(pe), 3'd0, 5'(e)};
   endfunction

   task automatic idle_rd(input int n);
      repeat (n) @(posedge rd_clk);
      #1;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      @(posedge rd_clk);
      #1;
      psel    = 1'b1;   // Setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge rd_clk);
      #1;
      penable = 1'b1;   // Access
      #1;
      check_value("apb write pready", 1, pready);
      err = pslverr;
      @(posedge rd_clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      @(posedge rd_clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge rd_clk);
      #1;
      penable = 1'b1;
      #1;
      check_value("apb read pready", 1, pready);
      data = prdata;   // Valid in the access cycle
      err  = pslverr;
      @(posedge rd_clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Config is quasi-static, so let it settle in both domains
   task automatic load_config(input apb_data_t ctrl, input apb_data_t thresh);
      logic err;
      apb_write(ADDR_CTRL, ctrl, err);
      check_value("config CTRL pslverr", 0, err);
      apb_write(ADDR_THRESH, thresh, err);
      check_value("config THRESH pslverr", 0, err);
      idle_rd(6);
   endtask

   task automatic push_word(input fifo_word_t d);
      @(posedge wr_clk);
      #1;
      wr_en   = 1'b1;
      wr_data = d;
      @(posedge wr_clk);
      #1;
      wr_en = 1'b0;
   endtask

   task automatic push_random(input int n);
      fifo_word_t w;
      repeat (n) begin
         w = fifo_word_t'({$random(seed), $random(seed)});
         model_q.push_back(w);
         push_word(w);
      end
   endtask

   // Fall-through: sample head and next, then pop on the following edge
   task automatic pop_word(output fifo_word_t head, output fifo_word_t next);
      int waited;
      @(posedge rd_clk);
      #1;
      waited = 0;
      while (rd_empty && waited < WAIT_MAX) begin
         @(posedge rd_clk);
         #1;
         waited++;
      end
      if (rd_empty) begin
         errors++;
         $display("read side still empty after %0d cycles at %0t", WAIT_MAX, $time);
      end
      head  = rd_data;
      next  = rd_data_next;
      rd_en = 1'b1;
      @(posedge rd_clk);
      #1;
      rd_en = 1'b0;
   endtask

   task automatic pop_and_compare(input string name, input bit two);
      fifo_word_t head;
      fifo_word_t next;
      pop_word(head, next);
      if (model_q.size() == 0) begin
         errors++;
         $display("%s popped a word the model never pushed", name);
      end else begin
         check_value({name, " rd_data"}, model_q[0], head);
         if (model_q.size() >= 2) check_value({name, " rd_data_next"}, model_q[1], next);
         void'(model_q.pop_front());
         if (two && model_q.size() > 0) void'(model_q.pop_front());   // Second word of the pair
      end
   endtask

   // Expected flags straight from occupancy and thresholds
   task automatic compare_flags(input string tag, input int occ, input int th_e,
                                input int th_pe, input int th_f, input int th_pf);
      check_value({tag, " wr_empty"},  occ <= th_e,  wr_empty);
      check_value({tag, " wr_pempty"}, occ <= th_pe, wr_pempty);
      check_value({tag, " wr_full"},   occ >= th_f,  wr_full);
      check_value({tag, " wr_pfull"},  occ >= th_pf, wr_pfull);
      check_value({tag, " rd_empty"},  occ <= th_e,  rd_empty);
      check_value({tag, " rd_pempty"}, occ <= th_pe, rd_pempty);
      check_value({tag, " rd_full"},   occ >= th_f,  rd_full);
      check_value({tag, " rd_pfull"},  occ >= th_pf, rd_pfull);
   endtask

   // *************************************************************************
   // Directed tests
   // *************************************************************************
   task automatic reg_access_test;
      apb_data_t data;
      logic      err;
      compare_flags("reset", 0, 0, 2, 16, 12);
      check_value("reset pready", 0, pready);
      check_value("reset pslverr", 0, pslverr);
      apb_read(ADDR_CTRL, data, err);
      check_value("reset CTRL", ctrl_word(1, 1, 0, 2'b00), data);
      check_value("reset CTRL pslverr", 0, err);
      apb_read(ADDR_THRESH, data, err);
      check_value("reset THRESH", thresh_word(0, 2, 16, 12), data);
      apb_read(ADDR_STATUS, data, err);
      check_value("reset STATUS", 0, data);
      apb_write(ADDR_CTRL, ctrl_word(1, 1, 1, 2'b01), err);
      apb_read(ADDR_CTRL, data, err);
      check_value("readback CTRL", ctrl_word(1, 1, 1, 2'b01), data);
      apb_write(ADDR_THRESH, thresh_word(1, 3, 11, 10), err);
      apb_read(ADDR_THRESH, data, err);
      check_value("readback THRESH", thresh_word(1, 3, 11, 10), data);
      apb_read(8'h0C, data, err);   // Hole in the map
      check_value("unmapped read pslverr", 1, err);
      apb_write(8'h10, 32'hFFFF_FFFF, err);
      check_value("unmapped write pslverr", 1, err);
      load_config(ctrl_word(1, 1, 0, 2'b00), thresh_word(0, 2, 16, 12));
   endtask

   task automatic full_depth_order;
      load_config(ctrl_word(1, 1, 0, PM_FULL), thresh_word(0, 2, 16, 12));
      push_random(16);   // Both pairs, both halves
      repeat (16) pop_and_compare("full order", 0);
   endtask

   task automatic power_save_depth;
      apb_data_t data;
      logic      err;
      int        waited;
      load_config(ctrl_word(1, 1, 0, PM_SAVE), thresh_word(0, 2, 8, 6));
      push_random(8);
      waited = 0;
      while (!wr_full && waited < WAIT_MAX) begin
         @(posedge wr_clk);
         #1;
         waited++;
      end
      check_value("power save wr_full", 1, wr_full);
      idle_rd(6);
      compare_flags("power save 8", 8, 0, 2, 8, 6);
      push_word(40'hDE_AD00_BEEF);   // Refused, not in the model
      data = '0;
      for (int i = 0; i < 8 && !data[0]; i++) apb_read(ADDR_STATUS, data, err);
      check_value("power save overflow", 1, data[0]);
      apb_write(ADDR_STATUS, 32'h1, err);
      apb_read(ADDR_STATUS, data, err);
      check_value("power save STATUS cleared", 0, data);
      repeat (8) pop_and_compare("power save order", 0);
   endtask

   task automatic double_read_pops;
      // Empty at 1 so a pop waits for a full pair
      load_config(ctrl_word(1, 1, 1, PM_FULL), thresh_word(1, 2, 16, 12));
      push_random(8);
      repeat (4) pop_and_compare("double read", 1);
      idle_rd(6);
      compare_flags("double read drained", 0, 1, 2, 16, 12);
      load_config(ctrl_word(1, 1, 0, PM_FULL), thresh_word(0, 2, 16, 12));
   endtask

   task automatic threshold_flags;
      int levels [7];
      int occ;
      levels = '{0, 2, 4, 7, 10, 6, 0};   // Hits each flag edge
      load_config(ctrl_word(1, 1, 0, PM_FULL), thresh_word(0, 3, 10, 6));
      occ = 0;
      foreach (levels[i]) begin
         while (occ < levels[i]) begin
            push_random(1);
            occ++;
         end
         while (occ > levels[i]) begin
            pop_and_compare("thresholds", 0);
            occ--;
         end
         idle_rd(6);
         compare_flags($sformatf("thresholds occ %0d", occ), occ, 0, 3, 10, 6);
      end
   endtask

   task automatic underflow_clear;
      apb_data_t data;
      logic      err;
      check_value("underflow start rd_empty", 1, rd_empty);
      @(posedge rd_clk);
      #1;
      rd_en = 1'b1;   // Pop with nothing stored
      @(posedge rd_clk);
      #1;
      rd_en = 1'b0;
      idle_rd(1);
      apb_read(ADDR_STATUS, data, err);
      check_value("underflow STATUS", 32'h2, data);
      apb_write(ADDR_STATUS, 32'h2, err);
      check_value("underflow STATUS write pslverr", 1, err);
      apb_read(ADDR_STATUS, data, err);
      check_value("underflow STATUS cleared", 0, data);
   endtask

   // *************************************************************************
   // Sequence and watchdog
   // *************************************************************************
   initial begin
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      wr_en    = 1'b0;
      wr_data  = '0;
      rd_en    = 1'b0;
      wr_rst_n = 1'b0;
      rd_rst_n = 1'b0;
      fork
         begin
            repeat (5) @(posedge wr_clk);
            #1;
            wr_rst_n = 1'b1;
         end
         begin
            repeat (5) @(posedge rd_clk);
            #1;
            rd_rst_n = 1'b1;
         end
      join
      reg_access_test();
      full_depth_order();
      power_save_depth();
      double_read_pops();
      threshold_flags();
      underflow_clear();
      idle_rd(2);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_T);
      $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_T);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: src.f
design/rxdp_fifo_pkg.sv
design/rxdp_cfg_pkg.sv
design/rxdp_cfg_regs.sv
design/rxdp_fifo_ram.sv
design/rxdp_fifo_ptr.sv
design/rxdp_async_fifo.sv
design/rxdp_top.sv
verification/rxdp_tb.sv

// File: Bender.yml
package:
  name: rxdp_fifo

sources:
  # Packages first, then the RTL bottom up
  - design/rxdp_fifo_pkg.sv
  - design/rxdp_cfg_pkg.sv
  - design/rxdp_cfg_regs.sv
  - design/rxdp_fifo_ram.sv
  - design/rxdp_fifo_ptr.sv
  - design/rxdp_async_fifo.sv
  - design/rxdp_top.sv
  - target: test
    files:
      - verification/rxdp_tb.sv
